//--- bridge_consts.svh
// Bridge width and timing constants
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// halfword address width of the 16-bit device.
`define RAM_ADDR_BITS 10

// number of halfwords in the device.
`define RAM_DEPTH (1 << `RAM_ADDR_BITS)

// cycles from a device strobe to its ready pulse, 1 or more.
`define RAM_WAIT 2

// word width on the requester side.
`define WORD_BITS 32

// halfword width on the device side.
`define HALF_BITS 16

`endif

//--- bridge_sequencer.sv
// Halfword access sequencer
`timescale 1ns/1ps
`default_nettype none

module bridge_sequencer (
	input  wire  i_clock,
	input  wire  i_rst,
	input  wire  i_enable,
	input  wire  i_rw,
	input  wire  i_ram_ready,
	output logic o_issue,
	output logic o_phase,
	output logic o_capture_low,
	output logic o_capture_high,
	output logic o_ready
);

	typedef enum logic [2:0] {
		st_idle,
		st_low_wait,
		st_high_issue,
		st_high_wait,
		st_done
	} state_t;

	state_t state;
	state_t state_next;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (i_enable) begin
					state_next = st_low_wait; // low half is issued on this edge.
				end
			end
			st_low_wait: begin
				if (i_ram_ready) begin
					state_next = st_high_issue;
				end
			end
			st_high_issue: begin
				state_next = st_high_wait;
			end
			st_high_wait: begin
				if (i_ram_ready) begin
					state_next = st_done;
				end
			end
			st_done: begin
				if (!i_enable) begin
					state_next = st_idle; // requester has seen o_ready.
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// the low issue leaves idle together with the request so the
	// strobe lands on the edge that samples i_enable.
	assign o_issue = ((state == st_idle) && i_enable) || (state == st_high_issue);
	assign o_phase = (state == st_high_issue);

	// read data is only valid in the ready cycle itself.
	assign o_capture_low  = (state == st_low_wait) && i_ram_ready && !i_rw;
	assign o_capture_high = (state == st_high_wait) && i_ram_ready && !i_rw;

	assign o_ready = (state == st_done);

	// direction must not change in the middle of a word access.
	property p_rw_stable;
		@(posedge i_clock) disable iff (i_rst)
		(i_enable && $past(i_enable)) |-> (i_rw == $past(i_rw));
	endproperty
	a_rw_stable: assert property (p_rw_stable)
		else $error("i_rw changed while i_enable high.");

	// dropping i_enable early would abandon a device access in flight.
	property p_no_early_drop;
		@(posedge i_clock) disable iff (i_rst)
		$fell(i_enable) |-> o_ready;
	endproperty
	a_no_early_drop: assert property (p_no_early_drop)
		else $error("i_enable fell before o_ready.");

	property p_no_stray_ready;
		@(posedge i_clock) disable iff (i_rst)
		(state == st_idle) |-> !i_ram_ready;
	endproperty
	a_no_stray_ready: assert property (p_no_stray_ready)
		else $error("device ready pulse while sequencer idle.");

endmodule

`default_nettype wire

//--- half_issue.sv
// Halfword request register
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module half_issue (
	input  wire                       i_clock,
	input  wire                       i_rst,
	input  mem_bridge_pkg::mem_req_t  i_req,
	input  wire                       i_issue,
	input  wire                       i_phase,
	output logic                      o_ram_enable,
	output mem_bridge_pkg::half_req_t o_ram_req
);

	mem_bridge_pkg::half_req_t req_next;

	// word index times two, plus the half select.
	always_comb begin
		req_next.rw = i_req.rw;
		req_next.addr = {i_req.addr[`RAM_ADDR_BITS:2], i_phase};
		if (i_phase) begin
			req_next.wdata = i_req.wdata[`WORD_BITS-1:`HALF_BITS];
		end else begin
			req_next.wdata = i_req.wdata[`HALF_BITS-1:0];
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ram_enable <= 1'b0;
		end else begin
			o_ram_enable <= i_issue; // one cycle strobe.
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_issue) begin
			o_ram_req <= req_next;
		end
	end

	// the sequencer spaces its issues by at least one idle cycle.
	property p_strobe_single;
		@(posedge i_clock) disable iff (i_rst)
		o_ram_enable |=> !o_ram_enable;
	endproperty
	a_strobe_single: assert property (p_strobe_single)
		else $error("device strobe held for two cycles.");

endmodule

`default_nettype wire

//--- mem_bridge_pkg.sv
// Memory bridge request types
`default_nettype none

`include "bridge_consts.svh"

package mem_bridge_pkg;

	// word request as held by the requester.
	typedef struct packed {
		logic rw; // 1 = write.
		logic [`WORD_BITS-1:0] addr; // byte address.
		logic [`WORD_BITS-1:0] wdata;
	} mem_req_t;

	// one halfword request as seen by the device.
	typedef struct packed {
		logic rw; // 1 = write.
		logic [`RAM_ADDR_BITS-1:0] addr; // halfword address.
		logic [`HALF_BITS-1:0] wdata;
	} half_req_t;

endpackage

`default_nettype wire

//--- mem_bridge_top.sv
// 32-bit to 16-bit memory bridge top
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module mem_bridge_top (
	input  wire                      i_clock,
	input  wire                      i_rst,
	input  wire                      i_enable,
	input  mem_bridge_pkg::mem_req_t i_req,
	output logic [`WORD_BITS-1:0]    o_rdata,
	output logic                     o_ready
);

	logic issue;
	logic phase;
	logic capture_low;
	logic capture_high;

	logic                      ram_enable;
	mem_bridge_pkg::half_req_t ram_req;
	logic [`HALF_BITS-1:0]     ram_rdata;
	logic                      ram_ready;

	bridge_sequencer u_sequencer (
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_enable       (i_enable),
		.i_rw           (i_req.rw),
		.i_ram_ready    (ram_ready),
		.o_issue        (issue),
		.o_phase        (phase),
		.o_capture_low  (capture_low),
		.o_capture_high (capture_high),
		.o_ready        (o_ready)
	);

	half_issue u_half_issue (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_req        (i_req),
		.i_issue      (issue),
		.i_phase      (phase),
		.o_ram_enable (ram_enable),
		.o_ram_req    (ram_req)
	);

	read_assembler u_read_assembler (
		.i_clock        (i_clock),
		.i_rst          (i_rst),
		.i_capture_low  (capture_low),
		.i_capture_high (capture_high),
		.i_ram_rdata    (ram_rdata),
		.o_rdata        (o_rdata)
	);

	sram16 u_sram (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_ram_enable (ram_enable),
		.i_ram_req    (ram_req),
		.o_ram_rdata  (ram_rdata),
		.o_ram_ready  (ram_ready)
	);

endmodule

`default_nettype wire

//--- project.f
+incdir+.
mem_bridge_pkg.sv
bridge_sequencer.sv
half_issue.sv
read_assembler.sv
sram16.sv
mem_bridge_top.sv
tb_mem_bridge.sv

//--- read_assembler.sv
// Read word assembly
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module read_assembler (
	input  wire                    i_clock,
	input  wire                    i_rst,
	input  wire                    i_capture_low,
	input  wire                    i_capture_high,
	input  wire  [`HALF_BITS-1:0]  i_ram_rdata,
	output logic [`WORD_BITS-1:0]  o_rdata
);

	logic [`HALF_BITS-1:0] half_low;
	logic [`HALF_BITS-1:0] half_high;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			half_low  <= '0;
			half_high <= '0;
		end else begin
			if (i_capture_low) begin
				half_low <= i_ram_rdata;
			end
			if (i_capture_high) begin
				half_high <= i_ram_rdata;
			end
		end
	end

	assign o_rdata = {half_high, half_low}; // held until the next read.

	property p_one_capture;
		@(posedge i_clock) disable iff (i_rst)
		!(i_capture_low && i_capture_high);
	endproperty
	a_one_capture: assert property (p_one_capture)
		else $error("both capture pulses high together.");

endmodule

`default_nettype wire

//--- sram16.sv
// Behavioural 16-bit memory device
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module sram16 (
	input  wire                       i_clock,
	input  wire                       i_rst,
	input  wire                       i_ram_enable,
	input  mem_bridge_pkg::half_req_t i_ram_req,
	output logic [`HALF_BITS-1:0]     o_ram_rdata,
	output logic                      o_ram_ready
);

	logic [`HALF_BITS-1:0] mem [0:`RAM_DEPTH-1];

	logic [`RAM_WAIT-1:0]      pipe_valid;
	mem_bridge_pkg::half_req_t pipe_req [0:`RAM_WAIT-1];
	mem_bridge_pkg::half_req_t cur_req;

	// array has no reset, so start from a known image.
	initial begin
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid[0] <= i_ram_enable;
			for (int k = 1; k < `RAM_WAIT; k++) begin
				pipe_valid[k] <= pipe_valid[k-1];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		pipe_req[0] <= i_ram_req;
		for (int k = 1; k < `RAM_WAIT; k++) begin
			pipe_req[k] <= pipe_req[k-1];
		end
	end

	assign cur_req = pipe_req[`RAM_WAIT-1]; // access due this cycle.
	assign o_ram_ready = pipe_valid[`RAM_WAIT-1];
	assign o_ram_rdata = mem[cur_req.addr];

	// write lands at the end of the ready cycle.
	always_ff @(posedge i_clock) begin
		if (o_ram_ready && cur_req.rw) begin
			mem[cur_req.addr] <= cur_req.wdata;
		end
	end

	// one access at a time, the device has no queue.
	property p_no_overlap;
		@(posedge i_clock) disable iff (i_rst)
		i_ram_enable |-> !(|pipe_valid);
	endproperty
	a_no_overlap: assert property (p_no_overlap)
		else $error("device strobe while access in flight.");

endmodule

`default_nettype wire

//--- tb_mem_bridge.sv
// Memory bridge testbench
`timescale 1ns/1ps
`default_nettype none

`include "bridge_consts.svh"

module tb_mem_bridge;

	localparam int latency = 2 * `RAM_WAIT + 3; // sampling edge to o_ready.
	localparam int word_count = `RAM_DEPTH / 2;
	localparam int access_count = 40;
	localparam int cycle_limit = access_count * (2 * `RAM_WAIT + 6) + 100;

	logic                      i_clock;
	logic                      i_rst;
	logic                      i_enable;
	mem_bridge_pkg::mem_req_t  i_req;
	logic [`WORD_BITS-1:0]     o_rdata;
	logic                      o_ready;

	logic [`WORD_BITS-1:0] ref_mem [int]; // word index to expected word.
	logic [`WORD_BITS-1:0] exp_rdata;
	logic [`WORD_BITS-1:0] written_addr [$];
	int cycle_count = 0;

	mem_bridge_top dut (
		.i_clock  (i_clock),
		.i_rst    (i_rst),
		.i_enable (i_enable),
		.i_req    (i_req),
		.o_rdata  (o_rdata),
		.o_ready  (o_ready)
	);

	initial begin
		i_clock = 1'b0;
		forever #50 i_clock = ~i_clock;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	// halfwords sit at index*2 and index*2+1, so the word index is bits N:2.
	function automatic int word_index(input logic [`WORD_BITS-1:0] addr);
		return int'(addr[`RAM_ADDR_BITS:2]);
	endfunction

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			stop_on_error($sformatf("run did not finish within %0d cycles.", cycle_limit));
		end
	end

	// o_ready low while i_enable stays low.
	a_idle_low: assert property (@(posedge i_clock) disable iff (i_rst)
		(!i_enable && !$past(i_enable)) |-> !o_ready)
		else stop_on_error($sformatf("FAIL time %0t o_ready got %b expected %b",
			$time, $sampled(o_ready), 1'b0));

	a_latency: assert property (@(posedge i_clock) disable iff (i_rst)
		$rose(i_enable) |-> ##latency !o_ready ##1 o_ready)
		else stop_on_error($sformatf("FAIL time %0t o_ready got %b expected %b",
			$time, $sampled(o_ready), !$sampled(o_ready)));

	a_ready_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_ready && i_enable) |=> o_ready)
		else stop_on_error($sformatf("FAIL time %0t o_ready got %b expected %b",
			$time, $sampled(o_ready), 1'b1));

	a_ready_fall: assert property (@(posedge i_clock) disable iff (i_rst)
		$fell(i_enable) |=> !o_ready)
		else stop_on_error($sformatf("FAIL time %0t o_ready got %b expected %b",
			$time, $sampled(o_ready), 1'b0));

	a_read_data: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_ready && !i_req.rw) |-> (o_rdata == exp_rdata))
		else stop_on_error($sformatf("FAIL time %0t o_rdata got %h expected %h",
			$time, $sampled(o_rdata), $sampled(exp_rdata)));

	// one word access, entered and left 1 ns after a rising edge.
	task automatic run_access(input logic rw, input logic [`WORD_BITS-1:0] addr,
			input logic [`WORD_BITS-1:0] wdata);
		int idx;
		int extra;
		idx = word_index(addr);
		extra = $urandom % 3; // 1 holds i_enable longer, 2 adds an idle gap.
		if (rw) begin
			ref_mem[idx] = wdata;
		end else if (ref_mem.exists(idx)) begin
			exp_rdata = ref_mem[idx];
		end else begin
			exp_rdata = '0; // unwritten words start at zero.
		end
		i_req.rw = rw;
		i_req.addr = addr;
		i_req.wdata = wdata;
		i_enable = 1'b1;
		do begin
			@(posedge i_clock);
			#1;
		end while (!o_ready);
		if (extra == 1) begin
			@(posedge i_clock);
			#1;
		end
		i_enable = 1'b0;
		@(posedge i_clock);
		#1;
		if (extra == 2) begin
			@(posedge i_clock);
			#1;
		end
	endtask

	initial begin
		int idx;
		logic [`WORD_BITS-1:0] addr;
		logic [`WORD_BITS-1:0] pattern;
		void'($urandom(32'he0094e4e));
		i_rst = 1'b1;
		i_enable = 1'b0;
		i_req = '0;
		exp_rdata = '0;
		repeat (5) @(posedge i_clock);
		#1;
		i_rst = 1'b0;

		// reset and idle.
		repeat (3) begin
			@(posedge i_clock);
			#1;
			assert (o_ready === 1'b0)
				else stop_on_error($sformatf("FAIL time %0t o_ready got %b expected %b",
					$time, o_ready, 1'b0));
		end

		// random round trip.
		repeat (16) begin
			idx = $urandom % word_count;
			addr = idx << 2;
			written_addr.push_back(addr);
			run_access(1'b1, addr, $urandom);
		end
		foreach (written_addr[i]) begin
			run_access(1'b0, written_addr[i], '0);
		end
		repeat (2) begin
			do begin
				idx = $urandom % word_count;
			end while (ref_mem.exists(idx));
			run_access(1'b0, idx << 2, '0);
		end

		// adjacent words n and n+1.
		idx = $urandom % (word_count - 1);
		pattern = $urandom;
		run_access(1'b1, idx << 2, pattern);
		run_access(1'b1, (idx + 1) << 2, ~pattern);
		run_access(1'b0, idx << 2, '0);
		run_access(1'b0, (idx + 1) << 2, '0);

		// byte offset and upper address bits are ignored.
		idx = $urandom % word_count;
		addr = (idx << 2) | 32'h1;
		run_access(1'b1, addr, $urandom);
		addr = (idx << 2) | 32'h2 | (32'h1 << (`RAM_ADDR_BITS + 2)) | 32'h8000_0000;
		run_access(1'b0, addr, '0);

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
